/* lc4_core.f */
+incdir+verilog
verilog/lc4_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_alu.sv
verilog/lc4_regfile.sv
verilog/lc4_hazard_unit.sv
verilog/lc4_core.sv
verification/lc4_core_checker.sv
verification/lc4_core_tb.sv

/* verification/lc4_core_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module lc4_core_checker (
    input wire                        gwe,
    input wire                        i_rst_n,
    input wire lc4_pkg::lc4_dmem_req_t i_dmem,
    input wire lc4_pkg::lc4_retire_t  i_retire,
    input wire lc4_pkg::lc4_stall_e   i_m_stall
);
    import lc4_pkg::*;

    int unsigned fail_count;

    // bubbles carry no architectural writes
    a_bubble_no_write: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_retire.stall != STALL_NONE |-> !i_retire.rf_we && !i_retire.nzp_we)
        else begin
            $error("bubble on the retire port writes the register file or NZP");
            fail_count++;
        end

    // only a real store in the memory stage may write data memory
    a_store_not_bubble: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_dmem.we |-> i_m_stall == STALL_NONE)
        else begin
            $error("data memory write from a bubble");
            fail_count++;
        end

    a_nzp_onehot: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_retire.stall == STALL_NONE && i_retire.nzp_we |-> $onehot(i_retire.nzp))
        else begin
            $error("retired NZP bits are not one-hot");
            fail_count++;
        end

    a_reset_no_store: assert property (@(posedge gwe) !i_rst_n |-> !i_dmem.we)
        else begin
            $error("data memory write enable high during reset");
            fail_count++;
        end

endmodule

bind lc4_core lc4_core_checker u_checker (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_dmem    (o_dmem),
    .i_retire  (o_retire),
    .i_m_stall (xm.stall)
);

`default_nettype wire

/* verification/lc4_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lc4_cfg.svh"

module lc4_core_tb;
    import lc4_pkg::*;

    localparam int CHAIN_LEN   = 24;
    localparam int LOAD_LEN    = 7;
    localparam int STORE_LEN   = 11;
    localparam int BRANCH_LEN  = 13;
    localparam int TOTAL_INSNS = CHAIN_LEN + LOAD_LEN + STORE_LEN + BRANCH_LEN;
    localparam int WATCHDOG_NS = (3 * TOTAL_INSNS + 50) * 10;

    logic          gwe;
    logic          i_rst_n;
    logic [15:0]   imem_addr;
    logic [15:0]   imem_data;
    logic [15:0]   dmem_rdata;
    lc4_dmem_req_t dmem_req;
    lc4_retire_t   retire;

    logic [15:0] imem [0:65535];
    logic [15:0] dmem [0:65535];
    logic [15:0] mdm  [0:65535];
    logic [31:0] lfsr;
    logic [15:0] prog [$];
    lc4_retire_t exp_rec [$];
    int          exp_gap [$];
    lc4_stall_e  exp_kind [$];
    logic [15:0] exp_st_addr [$];
    logic [15:0] exp_st_data [$];
    string       cur_test;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    lc4_core u_dut (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem       (dmem_req),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    initial gwe = 1'b0;
    always #5 gwe = ~gwe;

    assign imem_data  = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_req.addr];

    always @(posedge gwe) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr] <= dmem_req.wdata;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished retiring");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // galois lfsr stepped once per bit
    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [2:0] nzp_bits(input logic [15:0] v);
        if (v[15]) begin
            return 3'b100;
        end
        return (v == 16'h0) ? 3'b010 : 3'b001;
    endfunction

    // data memory contents depend on every address bit
    function automatic logic [15:0] fill_word(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ 16'hbc5a;
    endfunction

    function automatic logic [15:0] word_rr(input logic [3:0] op, input logic [2:0] rd,
                                            input logic [2:0] rs, input logic [2:0] sub,
                                            input logic [2:0] rt);
        return {op, rd, rs, sub, rt};
    endfunction

    function automatic logic [15:0] word_imm(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [2:0] rs, input logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [15:0] word_const(input logic [2:0] rd, input logic [8:0] imm);
        return {4'b1001, rd, imm};
    endfunction

    function automatic logic [15:0] word_br(input logic [2:0] mask, input logic [8:0] off);
        return {4'b0000, mask, off};
    endfunction

    task automatic compare_word(input string what, input logic [15:0] exp,
                                input logic [15:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // ISA reference model that walks the program in order
    task automatic run_model();
        logic [15:0] r [8];
        logic [15:0] pc;
        logic [15:0] insn;
        logic [15:0] v;
        logic [15:0] a;
        logic [2:0]  z;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [2:0]  sub;
        logic [2:0]  prev_rd;
        logic        wr;
        logic        rs_used;
        logic        rt_used;
        logic        br;
        logic        taken;
        logic        ld;
        logic        prev_ld;
        logic        prev_taken;
        lc4_retire_t rec;
        int          steps;
        for (int i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        pc         = `LC4_RESET_PC;
        z          = 3'b010;
        prev_ld    = 1'b0;
        prev_rd    = '0;
        prev_taken = 1'b0;
        steps      = 0;
        exp_rec.delete();
        exp_gap.delete();
        exp_kind.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        while (pc != 16'(`LC4_RESET_PC + prog.size()) && steps < 200) begin
            insn    = imem[pc];
            rd      = insn[11:9];
            rs      = insn[8:6];
            sub     = insn[5:3];
            rt      = insn[2:0];
            wr      = 1'b0;
            rs_used = 1'b0;
            rt_used = 1'b0;
            br      = 1'b0;
            taken   = 1'b0;
            ld      = 1'b0;
            v       = '0;
            case (insn[15:12])
                4'b0001: begin
                    if (sub[2]) begin
                        v       = r[rs] + {{11{insn[4]}}, insn[4:0]};
                        wr      = 1'b1;
                        rs_used = 1'b1;
                    end else if (sub == 3'd0 || sub == 3'd2) begin
                        v       = (sub == 3'd0) ? r[rs] + r[rt] : r[rs] - r[rt];
                        wr      = 1'b1;
                        rs_used = 1'b1;
                        rt_used = 1'b1;
                    end
                end
                4'b0101: begin
                    if (sub == 3'd0 || sub == 3'd2 || sub == 3'd3) begin
                        v       = (sub == 3'd0) ? (r[rs] & r[rt]) :
                                  (sub == 3'd2) ? (r[rs] | r[rt]) : (r[rs] ^ r[rt]);
                        wr      = 1'b1;
                        rs_used = 1'b1;
                        rt_used = 1'b1;
                    end
                end
                4'b0110: begin
                    a       = r[rs] + {{10{insn[5]}}, insn[5:0]};
                    v       = mdm[a];
                    wr      = 1'b1;
                    ld      = 1'b1;
                    rs_used = 1'b1;
                end
                4'b0111: begin
                    a       = r[rs] + {{10{insn[5]}}, insn[5:0]};
                    mdm[a]  = r[rd];
                    rs_used = 1'b1;
                    exp_st_addr.push_back(a);
                    exp_st_data.push_back(r[rd]);
                end
                4'b1001: begin
                    v  = {{7{insn[8]}}, insn[8:0]};
                    wr = 1'b1;
                end
                4'b0000: begin
                    br    = |rd;
                    taken = |(rd & z);
                end
                default: begin
                end
            endcase
            if (prev_taken) begin
                exp_gap.push_back(2);
                exp_kind.push_back(STALL_BRANCH);
            end else if (prev_ld && ((rs_used && rs == prev_rd) ||
                                     (rt_used && rt == prev_rd) || br)) begin
                exp_gap.push_back(1);
                exp_kind.push_back(STALL_LOAD);
            end else begin
                exp_gap.push_back(0);
                exp_kind.push_back(STALL_NONE);
            end
            rec        = '0;
            rec.stall  = STALL_NONE;
            rec.pc     = pc;
            rec.insn   = insn;
            rec.rf_we  = wr;
            rec.nzp_we = wr;
            rec.wsel   = rd;
            rec.wdata  = v;
            rec.nzp    = wr ? nzp_bits(v) : 3'b000;
            exp_rec.push_back(rec);
            if (wr) begin
                r[rd] = v;
                z     = nzp_bits(v);
            end
            prev_ld    = ld;
            prev_rd    = rd;
            prev_taken = taken;
            pc         = taken ? pc + 16'd1 + {{7{insn[8]}}, insn[8:0]} : pc + 16'd1;
            steps++;
        end
    endtask

    task automatic run_test(input string name);
        int          idx;
        int          gap;
        int          errs_before;
        logic        first;
        lc4_stall_e  kind;
        lc4_retire_t exp;
        cur_test    = name;
        errs_before = errors;
        @(posedge gwe);
        #1;
        i_rst_n = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            imem[a] = 16'h0000;
            dmem[a] = fill_word(16'(a));
            mdm[a]  = fill_word(16'(a));
        end
        foreach (prog[i]) begin
            imem[16'(`LC4_RESET_PC + i)] = prog[i];
        end
        run_model();
        repeat (3) @(posedge gwe);
        #1;
        i_rst_n = 1'b1;
        idx     = 0;
        gap     = 0;
        first   = 1'b1;
        kind    = STALL_NONE;
        while (idx < exp_rec.size()) begin
            @(negedge gwe);
            if (dmem_req.we) begin
                assert (exp_st_addr.size() > 0) else begin
                    $display("%s: data memory written with no store expected", cur_test);
                    errors++;
                end
                if (exp_st_addr.size() > 0) begin
                    compare_word("store addr", exp_st_addr.pop_front(), dmem_req.addr);
                    compare_word("store data", exp_st_data.pop_front(), dmem_req.wdata);
                end
            end
            if (retire.stall != STALL_NONE) begin
                if (first) begin
                    compare_word("fill code", 16'(STALL_FILL), 16'(retire.stall));
                end
                gap++;
                kind = retire.stall;
            end else begin
                exp = exp_rec[idx];
                if (!first) begin
                    compare_word("bubble count", 16'(exp_gap[idx]), 16'(gap));
                    if (gap != 0) begin
                        compare_word("bubble code", 16'(exp_kind[idx]), 16'(kind));
                    end
                end
                compare_word("pc", exp.pc, retire.pc);
                compare_word("insn", exp.insn, retire.insn);
                compare_word("rf_we", 16'(exp.rf_we), 16'(retire.rf_we));
                compare_word("nzp_we", 16'(exp.nzp_we), 16'(retire.nzp_we));
                if (exp.rf_we) begin
                    compare_word("wsel", 16'(exp.wsel), 16'(retire.wsel));
                    compare_word("wdata", exp.wdata, retire.wdata);
                    compare_word("nzp", 16'(exp.nzp), 16'(retire.nzp));
                end
                idx++;
                gap   = 0;
                first = 1'b0;
            end
        end
        assert (exp_st_addr.size() == 0) else begin
            $display("%s: %0d stores never reached data memory", cur_test, exp_st_addr.size());
            errors++;
        end
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s passed, %0d records", name, exp_rec.size());
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic build_chain();
        logic [2:0] kind;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] last_rd;
        prog.delete();
        last_rd = '0;
        for (int i = 0; i < CHAIN_LEN; i++) begin
            kind = 3'(rand_bits(3));
            rd   = 3'(rand_bits(3));
            // half the time depend on the previous result
            rs   = next_bit() ? last_rd : 3'(rand_bits(3));
            if (i < 4 || kind >= 3'd6) begin
                prog.push_back(word_const(rd, 9'(rand_bits(9))));
            end else if (kind == 3'd2) begin
                prog.push_back(word_imm(4'b0001, rd, rs, {1'b1, 5'(rand_bits(5))}));
            end else if (kind < 3'd2) begin
                prog.push_back(word_rr(4'b0001, rd, rs, {kind[0], 2'b00} >> 1, last_rd));
            end else begin
                prog.push_back(word_rr(4'b0101, rd, rs,
                                       (kind == 3'd3) ? 3'd0 : (kind == 3'd4) ? 3'd2 : 3'd3,
                                       3'(rand_bits(3))));
            end
            last_rd = rd;
        end
    endtask

    initial begin
        lfsr         = 32'h51d76899;
        i_rst_n      = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int a = 0; a < 65536; a++) begin
            imem[a] = 16'h0000;
            dmem[a] = fill_word(16'(a));
        end

        build_chain();
        run_test("alu_chain");

        prog = '{word_const(3'd1, 9'd16), word_imm(4'b0110, 3'd2, 3'd1, 6'd3),
                 word_rr(4'b0001, 3'd3, 3'd2, 3'd0, 3'd1),
                 word_imm(4'b0110, 3'd4, 3'd1, 6'h3e),
                 word_rr(4'b0101, 3'd5, 3'd1, 3'd0, 3'd4),
                 word_imm(4'b0110, 3'd6, 3'd1, 6'd5),
                 word_imm(4'b0001, 3'd6, 3'd6, 6'h21)};
        run_test("load_use");

        prog = '{word_const(3'd1, 9'h040), word_const(3'd2, 9'h1b3),
                 word_rr(4'b0001, 3'd3, 3'd2, 3'd0, 3'd2),
                 word_imm(4'b0111, 3'd3, 3'd1, 6'd2), word_const(3'd4, 9'd5),
                 word_imm(4'b0111, 3'd4, 3'd1, 6'd3),
                 word_imm(4'b0110, 3'd5, 3'd1, 6'd2),
                 word_imm(4'b0111, 3'd5, 3'd1, 6'd4),
                 word_imm(4'b0110, 3'd6, 3'd1, 6'd4),
                 word_imm(4'b0110, 3'd7, 3'd1, 6'd3),
                 word_rr(4'b0001, 3'd0, 3'd6, 3'd0, 3'd7)};
        run_test("store_bypass");

        // fill word at 0x0020 is negative, so the BRn after the load is taken
        prog = '{word_const(3'd1, 9'd3), word_br(3'b001, 9'd2),
                 word_const(3'd2, 9'd1), word_const(3'd3, 9'd2),
                 word_const(3'd4, 9'h1ff), word_br(3'b011, 9'd1),
                 word_imm(4'b0001, 3'd4, 3'd4, 6'h22), word_const(3'd1, 9'h020),
                 word_imm(4'b0110, 3'd5, 3'd1, 6'd0), word_br(3'b100, 9'd1),
                 word_const(3'd6, 9'd7), word_rr(4'b0001, 3'd7, 3'd5, 3'd0, 3'd4),
                 word_rr(4'b0101, 3'd0, 3'd7, 3'd3, 3'd7)};
        run_test("branch");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, errors, u_dut.u_checker.fail_count);
        if (errors == 0 && tests_failed == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/lc4_alu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lc4_cfg.svh"

module lc4_alu (
    input  wire lc4_pkg::lc4_ctrl_t i_ctrl,
    input  wire [`LC4_WORD_W-1:0]   i_pc,
    input  wire [`LC4_WORD_W-1:0]   i_rs_data,
    input  wire [`LC4_WORD_W-1:0]   i_rt_data,
    output logic [`LC4_WORD_W-1:0]  o_result
);
    import lc4_pkg::*;

    logic [`LC4_WORD_W-1:0] op_b;

    // immediate forms read no rt
    assign op_b = i_ctrl.rt_re ? i_rt_data : i_ctrl.imm;

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD: begin
                o_result = i_rs_data + op_b;
            end
            ALU_SUB: begin
                o_result = i_rs_data - op_b;
            end
            ALU_AND: begin
                o_result = i_rs_data & op_b;
            end
            ALU_OR: begin
                o_result = i_rs_data | op_b;
            end
            ALU_XOR: begin
                o_result = i_rs_data ^ op_b;
            end
            ALU_PASS_IMM: begin
                o_result = i_ctrl.imm;
            end
            // load/store effective address is base plus 6-bit offset
            ALU_ADDR: begin
                o_result = i_rs_data + i_ctrl.imm;
            end
            // branch target is relative to the next pc
            ALU_BR_TARGET: begin
                o_result = i_pc + 1'b1 + i_ctrl.imm;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/lc4_cfg.svh */
`ifndef LC4_CFG_SVH
`define LC4_CFG_SVH

// datapath width also used for addresses
`define LC4_WORD_W    16
`define LC4_REG_CNT   8
`define LC4_REG_SEL_W 3
`define LC4_RESET_PC  16'h8200

// instruction field positions
`define LC4_OP_HI     15
`define LC4_OP_LO     12
`define LC4_RD_HI     11
`define LC4_RD_LO     9
`define LC4_RS_HI     8
`define LC4_RS_LO     6
// sub-op field; its top bit also marks the immediate forms
`define LC4_SUB_HI    5
`define LC4_SUB_LO    3
`define LC4_RT_HI     2
`define LC4_RT_LO     0

`endif

/* verilog/lc4_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lc4_cfg.svh"

module lc4_core (
    input  wire                    gwe,
    input  wire                    i_rst_n,
    output logic [`LC4_WORD_W-1:0] o_imem_addr,
    input  wire  [`LC4_WORD_W-1:0] i_imem_data,
    output lc4_pkg::lc4_dmem_req_t o_dmem,
    input  wire  [`LC4_WORD_W-1:0] i_dmem_rdata,
    output lc4_pkg::lc4_retire_t   o_retire
);
    import lc4_pkg::*;

    // op_a carries rs, then the result
    // op_b carries rt, then store data, then load data
    typedef struct packed {
        lc4_stall_e             stall;
        logic [`LC4_WORD_W-1:0] pc;
        lc4_ctrl_t              ctrl;
        logic [`LC4_WORD_W-1:0] op_a;
        logic [`LC4_WORD_W-1:0] op_b;
    } stage_t;

    logic [`LC4_WORD_W-1:0] pc;
    logic [`LC4_WORD_W-1:0] fd_pc;
    logic [`LC4_WORD_W-1:0] fd_insn;
    lc4_stall_e             fd_stall;
    stage_t                 dx;
    stage_t                 xm;
    stage_t                 mw;
    logic [2:0]             nzp;

    lc4_ctrl_t              dec_ctrl;
    lc4_ctrl_t              d_ctrl;
    logic [`LC4_WORD_W-1:0] rf_rs;
    logic [`LC4_WORD_W-1:0] rf_rt;
    logic [`LC4_WORD_W-1:0] x_rs;
    logic [`LC4_WORD_W-1:0] x_rt;
    logic [`LC4_WORD_W-1:0] alu_result;
    logic [`LC4_WORD_W-1:0] st_data;
    logic [`LC4_WORD_W-1:0] wb_data;
    logic                   load_stall;
    logic                   m_st_from_w;
    logic                   br_taken;
    lc4_byp_e               x_rs_sel;
    lc4_byp_e               x_rt_sel;

    function automatic logic [2:0] nzp_of(input logic [`LC4_WORD_W-1:0] v);
        if (v == '0) begin
            return 3'b010;
        end
        return v[`LC4_WORD_W-1] ? 3'b100 : 3'b001;
    endfunction

    function automatic stage_t bubble(input lc4_stall_e code);
        stage_t b;
        b       = '0;
        b.stall = code;
        return b;
    endfunction

    // fetch
    assign o_imem_addr = pc;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc       <= `LC4_RESET_PC;
            fd_pc    <= '0;
            fd_insn  <= '0;
            fd_stall <= STALL_FILL;
        end else if (br_taken) begin
            pc       <= alu_result;
            fd_stall <= STALL_BRANCH;
        end else if (!load_stall) begin
            pc       <= pc + 1'b1;
            fd_pc    <= pc;
            fd_insn  <= i_imem_data;
            fd_stall <= STALL_NONE;
        end
    end

    // decode; bubbles in F/D decode as nothing
    lc4_decoder u_decoder (
        .i_insn (fd_insn),
        .o_ctrl (dec_ctrl)
    );

    assign d_ctrl = (fd_stall == STALL_NONE) ? dec_ctrl : '0;

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs_sel  (d_ctrl.rs),
        .i_rt_sel  (d_ctrl.rt),
        .i_rd_sel  (mw.ctrl.rd),
        .i_rd_we   (mw.ctrl.rf_we),
        .i_rd_data (wb_data),
        .o_rs_data (rf_rs),
        .o_rt_data (rf_rt)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctrl      (d_ctrl),
        .i_x_ctrl      (dx.ctrl),
        .i_m_ctrl      (xm.ctrl),
        .i_w_ctrl      (mw.ctrl),
        .o_load_stall  (load_stall),
        .o_x_rs_sel    (x_rs_sel),
        .o_x_rt_sel    (x_rt_sel),
        .o_m_st_from_w (m_st_from_w)
    );

    // execute with MX and WX bypass
    assign x_rs = (x_rs_sel == BYP_FROM_M) ? xm.op_a :
                  (x_rs_sel == BYP_FROM_W) ? wb_data : dx.op_a;
    assign x_rt = (x_rt_sel == BYP_FROM_M) ? xm.op_a :
                  (x_rt_sel == BYP_FROM_W) ? wb_data : dx.op_b;

    lc4_alu u_alu (
        .i_ctrl    (dx.ctrl),
        .i_pc      (dx.pc),
        .i_rs_data (x_rs),
        .i_rt_data (x_rt),
        .o_result  (alu_result)
    );

    assign br_taken = dx.ctrl.is_branch && |(dx.ctrl.nzp_mask & nzp);

    // stage registers and NZP
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dx  <= bubble(STALL_FILL);
            xm  <= bubble(STALL_FILL);
            mw  <= bubble(STALL_FILL);
            nzp <= 3'b010;
        end else begin
            if (br_taken) begin
                dx <= bubble(STALL_BRANCH);
            end else if (load_stall) begin
                dx <= bubble(STALL_LOAD);
            end else begin
                dx <= '{stall: fd_stall, pc: fd_pc, ctrl: d_ctrl, op_a: rf_rs, op_b: rf_rt};
            end
            xm <= '{stall: dx.stall, pc: dx.pc, ctrl: dx.ctrl, op_a: alu_result, op_b: x_rt};
            mw <= '{stall: xm.stall, pc: xm.pc, ctrl: xm.ctrl, op_a: xm.op_a,
                    op_b: i_dmem_rdata};
            // the younger execute result wins over a load in memory
            if (dx.ctrl.nzp_we && !dx.ctrl.is_load) begin
                nzp <= nzp_of(alu_result);
            end else if (xm.ctrl.is_load) begin
                nzp <= nzp_of(i_dmem_rdata);
            end
        end
    end

    // memory stage store data may come from writeback
    assign st_data = m_st_from_w ? wb_data : xm.op_b;
    assign o_dmem  = '{we:    xm.ctrl.is_store,
                       addr:  (xm.ctrl.is_load || xm.ctrl.is_store) ? xm.op_a : '0,
                       wdata: xm.ctrl.is_store ? st_data : '0};

    // writeback and retire record
    assign wb_data  = mw.ctrl.is_load ? mw.op_b : mw.op_a;
    assign o_retire = '{stall:  mw.stall,
                        pc:     mw.pc,
                        insn:   mw.ctrl.insn,
                        rf_we:  mw.ctrl.rf_we,
                        wsel:   mw.ctrl.rd,
                        wdata:  wb_data,
                        nzp_we: mw.ctrl.nzp_we,
                        nzp:    nzp_of(wb_data)};

endmodule

`default_nettype wire

/* verilog/lc4_decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lc4_cfg.svh"

module lc4_decoder (
    input  wire  [`LC4_WORD_W-1:0] i_insn,
    output lc4_pkg::lc4_ctrl_t     o_ctrl
);
    import lc4_pkg::*;

    lc4_opcode_e            opcode;
    logic [2:0]             sub_op;
    logic [`LC4_WORD_W-1:0] sext5;
    logic [`LC4_WORD_W-1:0] sext6;
    logic [`LC4_WORD_W-1:0] sext9;

    assign opcode = lc4_opcode_e'(i_insn[`LC4_OP_HI:`LC4_OP_LO]);
    assign sub_op = i_insn[`LC4_SUB_HI:`LC4_SUB_LO];
    assign sext5  = {{(`LC4_WORD_W-5){i_insn[4]}}, i_insn[4:0]};
    assign sext6  = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
    assign sext9  = {{(`LC4_WORD_W-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.insn   = i_insn;
        o_ctrl.rd     = i_insn[`LC4_RD_HI:`LC4_RD_LO];
        o_ctrl.rs     = i_insn[`LC4_RS_HI:`LC4_RS_LO];
        o_ctrl.rt     = i_insn[`LC4_RT_HI:`LC4_RT_LO];
        o_ctrl.alu_op = ALU_PASS_IMM;
        case (opcode)
            OP_BR: begin
                o_ctrl.nzp_mask  = i_insn[`LC4_RD_HI:`LC4_RD_LO];
                // an empty mask is the LC4 NOP
                o_ctrl.is_branch = |i_insn[`LC4_RD_HI:`LC4_RD_LO];
                o_ctrl.alu_op    = ALU_BR_TARGET;
                o_ctrl.imm       = sext9;
            end
            OP_ARITH: begin
                if (i_insn[`LC4_SUB_HI]) begin
                    o_ctrl.alu_op = ALU_ADD;
                    o_ctrl.imm    = sext5;
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rf_we  = 1'b1;
                end else if (sub_op == 3'b000 || sub_op == 3'b010) begin
                    o_ctrl.alu_op = (sub_op == 3'b000) ? ALU_ADD : ALU_SUB;
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = 1'b1;
                    o_ctrl.rf_we  = 1'b1;
                end
            end
            OP_LOGIC: begin
                // only register-register AND, OR, XOR
                if (sub_op == 3'b000 || sub_op == 3'b010 || sub_op == 3'b011) begin
                    o_ctrl.alu_op = (sub_op == 3'b000) ? ALU_AND :
                                    (sub_op == 3'b010) ? ALU_OR  : ALU_XOR;
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = 1'b1;
                    o_ctrl.rf_we  = 1'b1;
                end
            end
            OP_LDR: begin
                o_ctrl.alu_op  = ALU_ADDR;
                o_ctrl.imm     = sext6;
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rf_we   = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                // store data register sits in the rd field
                o_ctrl.rt       = i_insn[`LC4_RD_HI:`LC4_RD_LO];
                o_ctrl.alu_op   = ALU_ADDR;
                o_ctrl.imm      = sext6;
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            OP_CONST: begin
                o_ctrl.imm   = sext9;
                o_ctrl.rf_we = 1'b1;
            end
            default: begin
            end
        endcase
        // every register write also sets NZP
        o_ctrl.nzp_we = o_ctrl.rf_we;
    end

endmodule

`default_nettype wire

/* verilog/lc4_hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module lc4_hazard_unit (
    input  wire lc4_pkg::lc4_ctrl_t i_d_ctrl,
    input  wire lc4_pkg::lc4_ctrl_t i_x_ctrl,
    input  wire lc4_pkg::lc4_ctrl_t i_m_ctrl,
    input  wire lc4_pkg::lc4_ctrl_t i_w_ctrl,
    output logic                    o_load_stall,
    output lc4_pkg::lc4_byp_e       o_x_rs_sel,
    output lc4_pkg::lc4_byp_e       o_x_rt_sel,
    output logic                    o_m_st_from_w
);
    import lc4_pkg::*;

    logic d_rs_hit;
    logic d_rt_hit;

    // memory stage is younger than writeback, so it wins
    function automatic lc4_byp_e pick_src(input logic re, input lc4_reg_sel_t src,
                                          input lc4_ctrl_t m, input lc4_ctrl_t w);
        if (re && m.rf_we && m.rd == src) begin
            return BYP_FROM_M;
        end else if (re && w.rf_we && w.rd == src) begin
            return BYP_FROM_W;
        end
        return BYP_NONE;
    endfunction

    assign d_rs_hit = i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd;
    // store data from a load is caught later by the writeback-to-memory path
    assign d_rt_hit = i_d_ctrl.rt_re && !i_d_ctrl.is_store && i_d_ctrl.rt == i_x_ctrl.rd;

    // a branch behind a load waits for the load's NZP
    assign o_load_stall = i_x_ctrl.is_load && (d_rs_hit || d_rt_hit || i_d_ctrl.is_branch);

    assign o_x_rs_sel = pick_src(i_x_ctrl.rs_re, i_x_ctrl.rs, i_m_ctrl, i_w_ctrl);
    assign o_x_rt_sel = pick_src(i_x_ctrl.rt_re, i_x_ctrl.rt, i_m_ctrl, i_w_ctrl);

    assign o_m_st_from_w = i_m_ctrl.is_store && i_w_ctrl.rf_we && i_w_ctrl.rd == i_m_ctrl.rt;

endmodule

`default_nettype wire

/* verilog/lc4_pkg.sv */
`default_nettype none
`include "lc4_cfg.svh"

package lc4_pkg;

    typedef logic [`LC4_REG_SEL_W-1:0] lc4_reg_sel_t;

    // major opcodes kept in this core
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } lc4_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_IMM,
        ALU_ADDR,
        ALU_BR_TARGET
    } lc4_alu_op_e;

    // retire stall codes as seen on the retire port
    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        STALL_FILL   = 2'd1,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } lc4_stall_e;

    typedef enum logic [1:0] {
        BYP_NONE,
        BYP_FROM_M,
        BYP_FROM_W
    } lc4_byp_e;

    typedef struct packed {
        lc4_reg_sel_t           rs;
        lc4_reg_sel_t           rt;
        lc4_reg_sel_t           rd;
        logic                   rs_re;
        logic                   rt_re;
        logic                   rf_we;
        logic                   nzp_we;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch;
        logic [2:0]             nzp_mask;
        lc4_alu_op_e            alu_op;
        logic [`LC4_WORD_W-1:0] imm;
        logic [`LC4_WORD_W-1:0] insn;
    } lc4_ctrl_t;

    typedef struct packed {
        logic                   we;
        logic [`LC4_WORD_W-1:0] addr;
        logic [`LC4_WORD_W-1:0] wdata;
    } lc4_dmem_req_t;

    typedef struct packed {
        lc4_stall_e             stall;
        logic [`LC4_WORD_W-1:0] pc;
        logic [`LC4_WORD_W-1:0] insn;
        logic                   rf_we;
        lc4_reg_sel_t           wsel;
        logic [`LC4_WORD_W-1:0] wdata;
        logic                   nzp_we;
        logic [2:0]             nzp;
    } lc4_retire_t;

endpackage

`default_nettype wire

/* verilog/lc4_regfile.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lc4_cfg.svh"

module lc4_regfile (
    input  wire                        gwe,
    input  wire                        i_rst_n,
    input  wire lc4_pkg::lc4_reg_sel_t i_rs_sel,
    input  wire lc4_pkg::lc4_reg_sel_t i_rt_sel,
    input  wire lc4_pkg::lc4_reg_sel_t i_rd_sel,
    input  wire                        i_rd_we,
    input  wire [`LC4_WORD_W-1:0]      i_rd_data,
    output logic [`LC4_WORD_W-1:0]     o_rs_data,
    output logic [`LC4_WORD_W-1:0]     o_rt_data
);

    logic [`LC4_WORD_W-1:0] regs [`LC4_REG_CNT];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `LC4_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // write-through so decode sees the value writeback is storing
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

`default_nettype wire
